// File: logic/cpu_pkg.sv
package cpu_pkg;

	localparam int DATA_W = 8;
	localparam int ADDR_W = 16;

	// high byte of every zero-page address
	localparam logic [DATA_W-1:0] ZERO_PAGE = 8'h00;
	localparam logic [DATA_W-1:0] STACK_RESET = 8'hFF;

	// bit positions in P, bits 5 to 3 always read 1
	localparam int FLAG_N = 7;
	localparam int FLAG_V = 6;
	localparam int FLAG_I = 2;
	localparam int FLAG_Z = 1;
	localparam int FLAG_C = 0;

	typedef enum logic [2:0] {
		MODE_IMPL,
		MODE_ACCUM,
		MODE_IMM,
		MODE_ZPG,
		MODE_ABS,
		MODE_JMP,
		MODE_REL
	} adr_mode_t;

	typedef enum logic [3:0] {
		ALU_PASS,
		ALU_ADD,
		ALU_SUB,
		ALU_CMP,
		ALU_AND,
		ALU_OR,
		ALU_EOR,
		ALU_INC,
		ALU_DEC,
		ALU_ASL,
		ALU_LSR,
		ALU_ROL,
		ALU_ROR
	} alu_op_t;

	// SEL_MEM as a source is the operand on data_in
	typedef enum logic [2:0] {
		SEL_NONE,
		SEL_A,
		SEL_X,
		SEL_Y,
		SEL_S,
		SEL_MEM
	} reg_sel_t;

	typedef enum logic [2:0] {
		FLAG_NONE,
		FLAG_CLC,
		FLAG_SEC,
		FLAG_CLV,
		FLAG_CLI,
		FLAG_SEI
	} flag_op_t;

	typedef enum logic [2:0] {
		BR_NONE,
		BR_N,
		BR_V,
		BR_C,
		BR_Z
	} branch_cond_t;

endpackage

// File: logic/cpu_alu.sv
module cpu_alu (
	input  cpu_pkg::alu_op_t op,
	input  logic [cpu_pkg::DATA_W-1:0] a,
	input  logic [cpu_pkg::DATA_W-1:0] b,
	input  logic carry_in,
	output logic [cpu_pkg::DATA_W-1:0] result,
	output logic neg,
	output logic ov,
	output logic zero,
	output logic carry_out
);
	import cpu_pkg::*;

	logic sub_like;
	logic [DATA_W-1:0] b_eff;
	logic cin_eff;
	logic [DATA_W:0] sum;
	logic [DATA_W-1:0] flag_src;

	// one adder for add, subtract and compare
	assign sub_like = (op == ALU_SUB) || (op == ALU_CMP);
	assign b_eff = sub_like ? ~b : b;
	assign cin_eff = (op == ALU_CMP) ? 1'b1 : carry_in;
	assign sum = {1'b0, a} + {1'b0, b_eff} + {{DATA_W{1'b0}}, cin_eff};

	always_comb
	begin
		result = b;
		carry_out = carry_in;
		ov = 1'b0;
		case (op)
			ALU_ADD, ALU_SUB:
			begin
				result = sum[DATA_W-1:0];
				carry_out = sum[DATA_W];
				// operands alike in sign, result not
				ov = (a[DATA_W-1] == b_eff[DATA_W-1]) && (sum[DATA_W-1] != a[DATA_W-1]);
			end
			ALU_CMP:
			begin
				result = a;
				carry_out = sum[DATA_W];
			end
			ALU_AND: result = a & b;
			ALU_OR: result = a | b;
			ALU_EOR: result = a ^ b;
			ALU_INC: result = b + 1'b1;
			ALU_DEC: result = b - 1'b1;
			ALU_ASL: {carry_out, result} = {b, 1'b0};
			ALU_LSR: {result, carry_out} = {1'b0, b};
			ALU_ROL: {carry_out, result} = {b, carry_in};
			ALU_ROR: {result, carry_out} = {carry_in, b};
			// pass
			default: result = b;
		endcase
	end

	// compare flags come from the difference
	assign flag_src = (op == ALU_CMP) ? sum[DATA_W-1:0] : result;
	assign zero = (flag_src == '0);
	assign neg = flag_src[DATA_W-1];

endmodule

// File: logic/cpu_decode.sv
module cpu_decode (
	input  logic [cpu_pkg::DATA_W-1:0] opcode,
	output cpu_pkg::adr_mode_t mode,
	output cpu_pkg::alu_op_t alu_op,
	output cpu_pkg::reg_sel_t src_sel,
	output cpu_pkg::reg_sel_t dst_sel,
	output logic store,
	output logic flag_upd_nz,
	output logic flag_upd_c,
	output logic flag_upd_v,
	output cpu_pkg::flag_op_t flag_op,
	output cpu_pkg::branch_cond_t branch_cond,
	output logic branch_value
);
	import cpu_pkg::*;

	adr_mode_t mem_mode;

	// low two opcode bits pick the register in load/store columns
	function automatic reg_sel_t column_reg(input logic [1:0] bits);
		case (bits)
			2'b01: column_reg = SEL_A;
			2'b10: column_reg = SEL_X;
			default: column_reg = SEL_Y;
		endcase
	endfunction

	// x0, x2 and x9 are immediate, x4 to x6 zero page, xC to xE absolute
	assign mem_mode = opcode[2] ? (opcode[3] ? MODE_ABS : MODE_ZPG) : MODE_IMM;

	always_comb
	begin
		mode = MODE_IMPL;
		alu_op = ALU_PASS;
		src_sel = SEL_NONE;
		dst_sel = SEL_NONE;
		store = 1'b0;
		flag_upd_nz = 1'b0;
		flag_upd_c = 1'b0;
		flag_upd_v = 1'b0;
		flag_op = FLAG_NONE;
		branch_cond = BR_NONE;
		branch_value = 1'b0;
		case (opcode)
			// LDA LDX LDY
			8'hA9, 8'hA5, 8'hAD, 8'hA2, 8'hA6, 8'hAE, 8'hA0, 8'hA4, 8'hAC:
			begin
				mode = mem_mode;
				src_sel = SEL_MEM;
				dst_sel = column_reg(opcode[1:0]);
				flag_upd_nz = 1'b1;
			end
			// STA STX STY
			8'h85, 8'h8D, 8'h86, 8'h8E, 8'h84, 8'h8C:
			begin
				mode = mem_mode;
				src_sel = column_reg(opcode[1:0]);
				store = 1'b1;
			end
			// ORA AND EOR ADC SBC, operation in the top three bits
			8'h09, 8'h05, 8'h0D, 8'h29, 8'h25, 8'h2D, 8'h49, 8'h45, 8'h4D,
			8'h69, 8'h65, 8'h6D, 8'hE9, 8'hE5, 8'hED:
			begin
				mode = mem_mode;
				src_sel = SEL_MEM;
				dst_sel = SEL_A;
				flag_upd_nz = 1'b1;
				flag_upd_c = (opcode[6:5] == 2'b11);
				flag_upd_v = (opcode[6:5] == 2'b11);
				case (opcode[7:5])
					3'b000: alu_op = ALU_OR;
					3'b001: alu_op = ALU_AND;
					3'b010: alu_op = ALU_EOR;
					3'b011: alu_op = ALU_ADD;
					default: alu_op = ALU_SUB;
				endcase
			end
			// CMP against memory, CPX and CPY put the index on the a side
			8'hC9, 8'hC5, 8'hCD, 8'hE0, 8'hE4, 8'hEC, 8'hC0, 8'hC4, 8'hCC:
			begin
				mode = mem_mode;
				alu_op = ALU_CMP;
				flag_upd_nz = 1'b1;
				flag_upd_c = 1'b1;
				if (opcode[0])
					src_sel = SEL_MEM;
				else if (opcode[5])
					src_sel = SEL_X;
				else
					src_sel = SEL_Y;
			end
			// ASL ROL LSR ROR on A
			8'h0A, 8'h2A, 8'h4A, 8'h6A:
			begin
				mode = MODE_ACCUM;
				src_sel = SEL_A;
				dst_sel = SEL_A;
				flag_upd_nz = 1'b1;
				flag_upd_c = 1'b1;
				case (opcode[6:5])
					2'b00: alu_op = ALU_ASL;
					2'b01: alu_op = ALU_ROL;
					2'b10: alu_op = ALU_LSR;
					default: alu_op = ALU_ROR;
				endcase
			end
			// register steps and transfers
			8'hE8, 8'hC8, 8'hCA, 8'h88, 8'hAA, 8'h8A, 8'hA8, 8'h98, 8'hBA, 8'h9A:
			begin
				// TXS is the only one that keeps N and Z
				flag_upd_nz = (opcode != 8'h9A);
				case (opcode)
					8'hE8, 8'hC8: alu_op = ALU_INC;
					8'hCA, 8'h88: alu_op = ALU_DEC;
					default: alu_op = ALU_PASS;
				endcase
				case (opcode)
					8'hAA, 8'hA8: src_sel = SEL_A;
					8'hC8, 8'h88, 8'h98: src_sel = SEL_Y;
					8'hBA: src_sel = SEL_S;
					default: src_sel = SEL_X;
				endcase
				case (opcode)
					8'h8A, 8'h98: dst_sel = SEL_A;
					8'hC8, 8'h88, 8'hA8: dst_sel = SEL_Y;
					8'h9A: dst_sel = SEL_S;
					default: dst_sel = SEL_X;
				endcase
			end
			8'h18: flag_op = FLAG_CLC;
			8'h38: flag_op = FLAG_SEC;
			8'hB8: flag_op = FLAG_CLV;
			8'h58: flag_op = FLAG_CLI;
			8'h78: flag_op = FLAG_SEI;
			// branches, flag in bits 7:6 and wanted value in bit 5
			8'h10, 8'h30, 8'h50, 8'h70, 8'h90, 8'hB0, 8'hD0, 8'hF0:
			begin
				mode = MODE_REL;
				branch_value = opcode[5];
				case (opcode[7:6])
					2'b00: branch_cond = BR_N;
					2'b01: branch_cond = BR_V;
					2'b10: branch_cond = BR_C;
					default: branch_cond = BR_Z;
				endcase
			end
			8'h4C: mode = MODE_JMP;
			// NOP and every unknown opcode keep the defaults
			default:
				mode = MODE_IMPL;
		endcase
	end

endmodule

// File: logic/cpu_sequencer.sv
module cpu_sequencer #(
	parameter logic [cpu_pkg::ADDR_W-1:0] RESET_VECTOR = 16'h0200
) (
	input  logic clk,
	input  logic reset_routine,
	input  logic [cpu_pkg::DATA_W-1:0] data_in,
	input  cpu_pkg::adr_mode_t mode,
	input  logic store,
	input  cpu_pkg::branch_cond_t branch_cond,
	input  logic branch_value,
	input  logic [cpu_pkg::DATA_W-1:0] p,
	output logic [cpu_pkg::DATA_W-1:0] opcode,
	output logic [cpu_pkg::ADDR_W-1:0] adr,
	output logic rw,
	output logic sync,
	output logic exec
);
	import cpu_pkg::*;

	typedef enum logic [2:0] {
		ST_BOOT,
		ST_FETCH,
		ST_OP1,
		ST_OP2,
		ST_OP3
	} state_t;

	state_t state;
	logic [ADDR_W-1:0] pc;
	logic [ADDR_W-1:0] pc_inc;
	logic [ADDR_W-1:0] branch_target;
	logic [DATA_W-1:0] adr_low;
	logic flag_sel;
	logic taken;

	assign pc_inc = pc + 1'b1;
	// offset counts from the instruction after the branch
	assign branch_target = pc_inc + {{(ADDR_W-DATA_W){data_in[DATA_W-1]}}, data_in};

	always_comb
	begin
		case (branch_cond)
			BR_N: flag_sel = p[FLAG_N];
			BR_V: flag_sel = p[FLAG_V];
			BR_C: flag_sel = p[FLAG_C];
			BR_Z: flag_sel = p[FLAG_Z];
			// never matches, so no branch
			default: flag_sel = ~branch_value;
		endcase
	end

	assign taken = (flag_sel == branch_value);
	assign sync = (state == ST_FETCH);

	// operand cycle of each data-handling mode
	always_comb
	begin
		case (state)
			ST_OP1: exec = (mode == MODE_IMPL) || (mode == MODE_ACCUM) || (mode == MODE_IMM);
			ST_OP2: exec = (mode == MODE_ZPG);
			ST_OP3: exec = (mode == MODE_ABS);
			default: exec = 1'b0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (state == ST_FETCH)
			opcode <= data_in;
		if (state == ST_OP1)
			adr_low <= data_in;
	end

	// adr and rw are set one edge ahead of the cycle they describe
	always_ff @(posedge clk)
	begin
		if (reset_routine)
		begin
			state <= ST_BOOT;
			pc <= RESET_VECTOR;
			adr <= RESET_VECTOR;
			rw <= 1'b1;
		end
		else
		begin
			case (state)
				ST_FETCH:
				begin
					pc <= pc_inc;
					adr <= pc_inc;
					state <= ST_OP1;
				end
				ST_OP1:
					case (mode)
						MODE_IMM:
						begin
							pc <= pc_inc;
							adr <= pc_inc;
							state <= ST_FETCH;
						end
						MODE_ZPG:
						begin
							pc <= pc_inc;
							adr <= {ZERO_PAGE, data_in};
							rw <= ~store;
							state <= ST_OP2;
						end
						MODE_ABS, MODE_JMP:
						begin
							pc <= pc_inc;
							adr <= pc_inc;
							state <= ST_OP2;
						end
						MODE_REL:
						begin
							adr <= pc_inc;
							if (taken)
							begin
								pc <= branch_target;
								state <= ST_OP2;
							end
							else
							begin
								pc <= pc_inc;
								state <= ST_FETCH;
							end
						end
						// implied and accumulator, byte after opcode not consumed
						default:
						begin
							adr <= pc;
							state <= ST_FETCH;
						end
					endcase
				ST_OP2:
					case (mode)
						MODE_ABS:
						begin
							pc <= pc_inc;
							adr <= {data_in, adr_low};
							rw <= ~store;
							state <= ST_OP3;
						end
						MODE_JMP:
						begin
							pc <= {data_in, adr_low};
							adr <= {data_in, adr_low};
							state <= ST_FETCH;
						end
						// end of zero-page access or taken branch
						default:
						begin
							rw <= 1'b1;
							adr <= pc;
							state <= ST_FETCH;
						end
					endcase
				// boot and end of absolute access
				default:
				begin
					rw <= 1'b1;
					adr <= pc;
					state <= ST_FETCH;
				end
			endcase
		end
	end

endmodule

// File: logic/cpu_datapath.sv
module cpu_datapath (
	input  logic clk,
	input  logic reset_routine,
	input  logic exec,
	input  logic [cpu_pkg::DATA_W-1:0] data_in,
	input  cpu_pkg::alu_op_t alu_op,
	input  cpu_pkg::reg_sel_t src_sel,
	input  cpu_pkg::reg_sel_t dst_sel,
	input  logic flag_upd_nz,
	input  logic flag_upd_c,
	input  logic flag_upd_v,
	input  cpu_pkg::flag_op_t flag_op,
	output logic [cpu_pkg::DATA_W-1:0] data_out,
	output logic [cpu_pkg::DATA_W-1:0] p,
	output logic [cpu_pkg::DATA_W-1:0] dbg_a,
	output logic [cpu_pkg::DATA_W-1:0] dbg_x,
	output logic [cpu_pkg::DATA_W-1:0] dbg_y,
	output logic [cpu_pkg::DATA_W-1:0] dbg_s,
	output logic [cpu_pkg::DATA_W-1:0] dbg_p
);
	import cpu_pkg::*;

	logic [DATA_W-1:0] a_reg;
	logic [DATA_W-1:0] x_reg;
	logic [DATA_W-1:0] y_reg;
	logic [DATA_W-1:0] s_reg;
	logic flag_n;
	logic flag_v;
	logic flag_i;
	logic flag_z;
	logic flag_c;

	logic [DATA_W-1:0] src_val;
	logic cmp_index;
	logic [DATA_W-1:0] alu_a;
	logic [DATA_W-1:0] alu_b;
	logic [DATA_W-1:0] alu_result;
	logic alu_neg;
	logic alu_ov;
	logic alu_zero;
	logic alu_carry;

	always_comb
	begin
		case (src_sel)
			SEL_A: src_val = a_reg;
			SEL_X: src_val = x_reg;
			SEL_Y: src_val = y_reg;
			SEL_S: src_val = s_reg;
			SEL_MEM: src_val = data_in;
			default: src_val = '0;
		endcase
	end

	// CPX and CPY compare the index against the operand
	assign cmp_index = (alu_op == ALU_CMP) && ((src_sel == SEL_X) || (src_sel == SEL_Y));
	assign alu_a = cmp_index ? src_val : a_reg;
	assign alu_b = cmp_index ? data_in : src_val;

	cpu_alu alu (
		.op(alu_op),
		.a(alu_a),
		.b(alu_b),
		.carry_in(flag_c),
		.result(alu_result),
		.neg(alu_neg),
		.ov(alu_ov),
		.zero(alu_zero),
		.carry_out(alu_carry)
	);

	always_comb
	begin
		p = '1;
		p[FLAG_N] = flag_n;
		p[FLAG_V] = flag_v;
		p[FLAG_I] = flag_i;
		p[FLAG_Z] = flag_z;
		p[FLAG_C] = flag_c;
	end

	always_ff @(posedge clk)
	begin
		if (reset_routine)
		begin
			a_reg <= '0;
			x_reg <= '0;
			y_reg <= '0;
			s_reg <= STACK_RESET;
			flag_n <= 1'b0;
			flag_v <= 1'b0;
			flag_i <= 1'b1;
			flag_z <= 1'b0;
			flag_c <= 1'b0;
		end
		else if (exec)
		begin
			case (dst_sel)
				SEL_A: a_reg <= alu_result;
				SEL_X: x_reg <= alu_result;
				SEL_Y: y_reg <= alu_result;
				SEL_S: s_reg <= alu_result;
				default: ;
			endcase
			if (flag_upd_nz)
			begin
				flag_n <= alu_neg;
				flag_z <= alu_zero;
			end
			if (flag_upd_c)
				flag_c <= alu_carry;
			if (flag_upd_v)
				flag_v <= alu_ov;
			// explicit flag instructions
			case (flag_op)
				FLAG_CLC: flag_c <= 1'b0;
				FLAG_SEC: flag_c <= 1'b1;
				FLAG_CLV: flag_v <= 1'b0;
				FLAG_CLI: flag_i <= 1'b0;
				FLAG_SEI: flag_i <= 1'b1;
				default: ;
			endcase
		end
	end

	// store data is the named register
	assign data_out = src_val;

	assign dbg_a = a_reg;
	assign dbg_x = x_reg;
	assign dbg_y = y_reg;
	assign dbg_s = s_reg;
	assign dbg_p = p;

endmodule

// File: logic/cpu_top.sv
module cpu_top #(
	parameter logic [cpu_pkg::ADDR_W-1:0] RESET_VECTOR = 16'h0200
) (
	input  logic clk,
	input  logic reset_routine,
	input  logic [cpu_pkg::DATA_W-1:0] data_in,
	output logic [cpu_pkg::ADDR_W-1:0] adr,
	output logic [cpu_pkg::DATA_W-1:0] data_out,
	output logic rw,
	output logic sync,
	output logic [cpu_pkg::DATA_W-1:0] dbg_a,
	output logic [cpu_pkg::DATA_W-1:0] dbg_x,
	output logic [cpu_pkg::DATA_W-1:0] dbg_y,
	output logic [cpu_pkg::DATA_W-1:0] dbg_s,
	output logic [cpu_pkg::DATA_W-1:0] dbg_p
);
	import cpu_pkg::*;

	// opcode register out of the sequencer
	logic [DATA_W-1:0] opcode;

	// decoded controls
	adr_mode_t mode;
	alu_op_t alu_op;
	reg_sel_t src_sel;
	reg_sel_t dst_sel;
	logic store;
	logic flag_upd_nz;
	logic flag_upd_c;
	logic flag_upd_v;
	flag_op_t flag_op;
	branch_cond_t branch_cond;
	logic branch_value;

	// sequencer to datapath and back
	logic exec;
	logic [DATA_W-1:0] p;

	// all wire names match the port names
	cpu_decode decode (.*);

	cpu_sequencer #(
		.RESET_VECTOR(RESET_VECTOR)
	) sequencer (.*);

	cpu_datapath datapath (.*);

endmodule

// File: tb/tb_checker.sv
module tb_checker #(
	parameter int NUM_INSTR = 4000,
	parameter logic [cpu_pkg::ADDR_W-1:0] RESET_VECTOR = 16'h0200
) (
	input  logic clk,
	input  logic reset_routine,
	input  logic [cpu_pkg::ADDR_W-1:0] adr,
	input  logic [cpu_pkg::DATA_W-1:0] data_out,
	input  logic rw,
	input  logic sync,
	input  logic [cpu_pkg::DATA_W-1:0] dbg_a,
	input  logic [cpu_pkg::DATA_W-1:0] dbg_x,
	input  logic [cpu_pkg::DATA_W-1:0] dbg_y,
	input  logic [cpu_pkg::DATA_W-1:0] dbg_s,
	input  logic [cpu_pkg::DATA_W-1:0] dbg_p,
	input  logic [cpu_pkg::DATA_W-1:0] image [0:(1 << cpu_pkg::ADDR_W) - 1],
	output logic done,
	output int error_total
);
	timeunit 1ns;
	timeprecision 1ps;

	import cpu_pkg::*;

	logic [7:0] model_mem [0:(1 << ADDR_W) - 1];

	// architectural state of the model
	logic [15:0] m_pc;
	logic [7:0] m_a;
	logic [7:0] m_x;
	logic [7:0] m_y;
	logic [7:0] m_s;
	logic m_n;
	logic m_v;
	logic m_i;
	logic m_z;
	logic m_c;

	// store the current instruction still owes the bus
	logic st_pending;
	logic [15:0] st_adr;
	logic [7:0] st_dat;

	logic started;
	int exp_cycles;
	int cycle_count;
	int steps;
	int reset_errs;
	int pc_errs;
	int reg_errs;
	int write_errs;
	int cycle_errs;

	assign error_total = reset_errs + pc_errs + reg_errs + write_errs + cycle_errs;

	initial
	begin
		$timeformat(-9, 0, " ns", 0);
		done = 1'b0;
		started = 1'b0;
		st_pending = 1'b0;
		exp_cycles = 0;
		cycle_count = 0;
		steps = 0;
		reset_errs = 0;
		pc_errs = 0;
		reg_errs = 0;
		write_errs = 0;
		cycle_errs = 0;
	end

	function automatic int differs(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual !== expected)
		begin
			$display("FAIL %t %s: expected %h, got %h", $time, name, expected, actual);
			return 1;
		end
		return 0;
	endfunction

	function automatic void set_nz(input logic [7:0] v);
		m_n = v[7];
		m_z = (v == 8'h00);
	endfunction

	// binary ADC with SBC passing the inverted operand
	function automatic void add_with_carry(input logic [7:0] operand);
		int unsigned_sum;
		int signed_sum;
		unsigned_sum = int'(m_a) + int'(operand) + int'(m_c);
		signed_sum = int'($signed(m_a)) + int'($signed(operand)) + int'(m_c);
		// V when the signed result leaves the 8-bit range
		m_v = (signed_sum > 127) || (signed_sum < -128);
		m_c = (unsigned_sum > 255);
		m_a = 8'(unsigned_sum);
		set_nz(m_a);
	endfunction

	function automatic void compare_with(input logic [7:0] lhs, input logic [7:0] rhs);
		m_c = (lhs >= rhs);
		set_nz(lhs - rhs);
	endfunction

	function automatic void expect_store(input logic [15:0] where, input logic [7:0] value);
		st_pending = 1'b1;
		st_adr = where;
		st_dat = value;
		model_mem[where] = value;
	endfunction

	// addressing mode of each kept opcode
	function automatic adr_mode_t mode_of(input logic [7:0] op);
		case (op)
			8'hA9, 8'hA2, 8'hA0, 8'h09, 8'h29, 8'h49, 8'h69, 8'hE9, 8'hC9, 8'hE0, 8'hC0:
				return MODE_IMM;
			8'hA5, 8'hA6, 8'hA4, 8'h85, 8'h86, 8'h84, 8'h05, 8'h25, 8'h45, 8'h65,
			8'hE5, 8'hC5, 8'hE4, 8'hC4:
				return MODE_ZPG;
			8'hAD, 8'hAE, 8'hAC, 8'h8D, 8'h8E, 8'h8C, 8'h0D, 8'h2D, 8'h4D, 8'h6D,
			8'hED, 8'hCD, 8'hEC, 8'hCC:
				return MODE_ABS;
			8'h4C:
				return MODE_JMP;
			8'h10, 8'h30, 8'h50, 8'h70, 8'h90, 8'hB0, 8'hD0, 8'hF0:
				return MODE_REL;
			8'h0A, 8'h2A, 8'h4A, 8'h6A:
				return MODE_ACCUM;
			default:
				return MODE_IMPL;
		endcase
	endfunction

	function automatic void load_reset_state();
		m_pc = RESET_VECTOR;
		m_a = 8'h00;
		m_x = 8'h00;
		m_y = 8'h00;
		m_s = STACK_RESET;
		m_n = 1'b0;
		m_v = 1'b0;
		m_i = 1'b1;
		m_z = 1'b0;
		m_c = 1'b0;
	endfunction

	// executes one instruction at m_pc
	task automatic step_model();
		logic [7:0] op;
		logic [7:0] b1;
		logic [7:0] b2;
		logic [15:0] ea;
		logic [7:0] val;
		logic [15:0] next_pc;
		logic take;
		logic carry_old;
		adr_mode_t mode;
		op = model_mem[m_pc];
		b1 = model_mem[m_pc + 16'd1];
		b2 = model_mem[m_pc + 16'd2];
		mode = mode_of(op);
		ea = 16'h0000;
		val = 8'h00;
		take = 1'b0;
		carry_old = m_c;
		case (mode)
			MODE_IMM:
			begin
				val = b1;
				next_pc = m_pc + 16'd2;
				exp_cycles = 2;
			end
			MODE_ZPG:
			begin
				ea = {8'h00, b1};
				val = model_mem[ea];
				next_pc = m_pc + 16'd2;
				exp_cycles = 3;
			end
			MODE_ABS:
			begin
				ea = {b2, b1};
				val = model_mem[ea];
				next_pc = m_pc + 16'd3;
				exp_cycles = 4;
			end
			MODE_JMP:
			begin
				next_pc = {b2, b1};
				exp_cycles = 3;
			end
			MODE_REL:
			begin
				case (op)
					8'h10: take = !m_n;
					8'h30: take = m_n;
					8'h50: take = !m_v;
					8'h70: take = m_v;
					8'h90: take = !m_c;
					8'hB0: take = m_c;
					8'hD0: take = !m_z;
					default: take = m_z;
				endcase
				next_pc = m_pc + 16'd2;
				exp_cycles = 2;
				if (take)
				begin
					next_pc = next_pc + {{8{b1[7]}}, b1};
					exp_cycles = 3;
				end
			end
			default:
			begin
				next_pc = m_pc + 16'd1;
				exp_cycles = 2;
			end
		endcase
		case (op)
			8'hA9, 8'hA5, 8'hAD:
			begin
				m_a = val;
				set_nz(m_a);
			end
			8'hA2, 8'hA6, 8'hAE:
			begin
				m_x = val;
				set_nz(m_x);
			end
			8'hA0, 8'hA4, 8'hAC:
			begin
				m_y = val;
				set_nz(m_y);
			end
			8'h85, 8'h8D: expect_store(ea, m_a);
			8'h86, 8'h8E: expect_store(ea, m_x);
			8'h84, 8'h8C: expect_store(ea, m_y);
			8'h09, 8'h05, 8'h0D:
			begin
				m_a = m_a | val;
				set_nz(m_a);
			end
			8'h29, 8'h25, 8'h2D:
			begin
				m_a = m_a & val;
				set_nz(m_a);
			end
			8'h49, 8'h45, 8'h4D:
			begin
				m_a = m_a ^ val;
				set_nz(m_a);
			end
			8'h69, 8'h65, 8'h6D: add_with_carry(val);
			8'hE9, 8'hE5, 8'hED: add_with_carry(~val);
			8'hC9, 8'hC5, 8'hCD: compare_with(m_a, val);
			8'hE0, 8'hE4, 8'hEC: compare_with(m_x, val);
			8'hC0, 8'hC4, 8'hCC: compare_with(m_y, val);
			8'h0A:
			begin
				m_c = m_a[7];
				m_a = {m_a[6:0], 1'b0};
				set_nz(m_a);
			end
			8'h4A:
			begin
				m_c = m_a[0];
				m_a = {1'b0, m_a[7:1]};
				set_nz(m_a);
			end
			8'h2A:
			begin
				m_c = m_a[7];
				m_a = {m_a[6:0], carry_old};
				set_nz(m_a);
			end
			8'h6A:
			begin
				m_c = m_a[0];
				m_a = {carry_old, m_a[7:1]};
				set_nz(m_a);
			end
			8'hE8:
			begin
				m_x = m_x + 8'd1;
				set_nz(m_x);
			end
			8'hC8:
			begin
				m_y = m_y + 8'd1;
				set_nz(m_y);
			end
			8'hCA:
			begin
				m_x = m_x - 8'd1;
				set_nz(m_x);
			end
			8'h88:
			begin
				m_y = m_y - 8'd1;
				set_nz(m_y);
			end
			8'hAA:
			begin
				m_x = m_a;
				set_nz(m_x);
			end
			8'h8A:
			begin
				m_a = m_x;
				set_nz(m_a);
			end
			8'hA8:
			begin
				m_y = m_a;
				set_nz(m_y);
			end
			8'h98:
			begin
				m_a = m_y;
				set_nz(m_a);
			end
			8'hBA:
			begin
				m_x = m_s;
				set_nz(m_x);
			end
			// TXS sets no flags
			8'h9A: m_s = m_x;
			8'h18: m_c = 1'b0;
			8'h38: m_c = 1'b1;
			8'hB8: m_v = 1'b0;
			8'h58: m_i = 1'b0;
			8'h78: m_i = 1'b1;
			default: ;
		endcase
		m_pc = next_pc;
	endtask

	task automatic check_write();
		if (!st_pending)
		begin
			$display("unexpected write of %h to address %h at %t, no store was predicted",
				data_out, adr, $time);
			write_errs++;
		end
		else
		begin
			write_errs += differs("write adr", st_adr, adr);
			write_errs += differs("data_out", {8'h00, st_dat}, {8'h00, data_out});
			st_pending = 1'b0;
		end
	endtask

	task automatic on_sync();
		if (!started)
		begin
			// image is untouched until the first fetch
			model_mem = image;
			load_reset_state();
			started = 1'b1;
		end
		else
		begin
			cycle_errs += differs("cycles", 16'(exp_cycles), 16'(cycle_count));
			if (st_pending)
			begin
				$display("the store to %h predicted before %t never appeared on the bus",
					st_adr, $time);
				write_errs++;
				st_pending = 1'b0;
			end
		end
		pc_errs += differs("adr", m_pc, adr);
		reg_errs += differs("dbg_a", {8'h00, m_a}, {8'h00, dbg_a});
		reg_errs += differs("dbg_x", {8'h00, m_x}, {8'h00, dbg_x});
		reg_errs += differs("dbg_y", {8'h00, m_y}, {8'h00, dbg_y});
		reg_errs += differs("dbg_s", {8'h00, m_s}, {8'h00, dbg_s});
		reg_errs += differs("dbg_p", {8'h00, m_n, m_v, 3'b111, m_i, m_z, m_c},
			{8'h00, dbg_p});
		cycle_count = 1;
		if (steps == NUM_INSTR)
		begin
			$display("%0d instructions, errors reset %0d pc %0d regs %0d writes %0d cycles %0d",
				steps, reset_errs, pc_errs, reg_errs, write_errs, cycle_errs);
			done = 1'b1;
		end
		else
		begin
			step_model();
			steps++;
		end
	endtask

	// outputs settle after the rising edge, so sample on the falling one
	always @(negedge clk)
	begin
		if (!done)
		begin
			if (reset_routine)
			begin
				reset_errs += differs("rw", 16'd1, {15'd0, rw});
				reset_errs += differs("sync", 16'd0, {15'd0, sync});
			end
			else
			begin
				if (rw === 1'b0)
					check_write();
				if (sync === 1'b1)
					on_sync();
				else
					cycle_count++;
			end
		end
	end

endmodule

// File: tb/tb_top.sv
module tb_top;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_INSTR = 4000;
	localparam int SEED = 98753;
	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 5;
	localparam int MEM_SIZE = 65536;
	// four cycles per instruction at most and doubled for margin
	localparam int WATCHDOG_NS = NUM_INSTR * 4 * CLK_PERIOD * 2;
	localparam logic [15:0] RESET_VECTOR = 16'h8000;

	logic clk;
	logic reset_routine;
	logic [7:0] data_in;
	logic [15:0] adr;
	logic [7:0] data_out;
	logic rw;
	logic sync;
	logic [7:0] dbg_a;
	logic [7:0] dbg_x;
	logic [7:0] dbg_y;
	logic [7:0] dbg_s;
	logic [7:0] dbg_p;

	logic [7:0] mem [0:MEM_SIZE-1];
	logic done;
	int error_total;

	always #(CLK_PERIOD / 2) clk = ~clk;

	// combinational read in the same cycle as adr
	assign data_in = mem[adr];

	// a write lands on the edge that ends the write cycle
	always @(posedge clk)
	begin
		if (rw == 1'b0)
			mem[adr] <= data_out;
	end

	cpu_top #(
		.RESET_VECTOR(RESET_VECTOR)
	) DUT (
		.clk(clk),
		.reset_routine(reset_routine),
		.data_in(data_in),
		.adr(adr),
		.data_out(data_out),
		.rw(rw),
		.sync(sync),
		.dbg_a(dbg_a),
		.dbg_x(dbg_x),
		.dbg_y(dbg_y),
		.dbg_s(dbg_s),
		.dbg_p(dbg_p)
	);

	tb_checker #(
		.NUM_INSTR(NUM_INSTR),
		.RESET_VECTOR(RESET_VECTOR)
	) model_check (
		.clk(clk),
		.reset_routine(reset_routine),
		.adr(adr),
		.data_out(data_out),
		.rw(rw),
		.sync(sync),
		.dbg_a(dbg_a),
		.dbg_x(dbg_x),
		.dbg_y(dbg_y),
		.dbg_s(dbg_s),
		.dbg_p(dbg_p),
		.image(mem),
		.done(done),
		.error_total(error_total)
	);

	initial
	begin
		int unsigned first_draw;
		clk = 1'b0;
		reset_routine = 1'b1;
		first_draw = $urandom(SEED);
		// every byte decodes, so any image is a program
		mem[0] = 8'(first_draw);
		for (int i = 1; i < MEM_SIZE; i++)
			mem[i] = 8'($urandom);
		repeat (RESET_CYCLES) @(posedge clk);
		reset_routine <= 1'b0;
		wait (done);
		if (error_total == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	// watchdog
	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the core stopped before %0d instructions",
			WATCHDOG_NS, NUM_INSTR);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: sim.f
logic/cpu_pkg.sv
logic/cpu_alu.sv
logic/cpu_decode.sv
logic/cpu_sequencer.sv
logic/cpu_datapath.sv
logic/cpu_top.sv
tb/tb_checker.sv
tb/tb_top.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator, run it and check the verdict"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal --top-module tb_top -f sim.f
	@out=$$(./obj_dir/Vtb_top); echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir
